// File: logic/memCtrlPkg.sv
`default_nettype none

package memCtrlPkg;

    // bus and RAM widths
    localparam int AddrWidth = 32;
    localparam int WordWidth = 32;
    localparam int ByteWidth = 8;

    // byte count of one transfer, 1 to 4
    localparam int LenWidth = 3;

    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [WordWidth-1:0] wordT;
    typedef logic [ByteWidth-1:0] memByteT;
    typedef logic [LenWidth-1:0]  lenT;

    // instruction fetch always reads a whole word
    localparam lenT FetchLen = 3'd4;

    typedef enum logic [0:0] {
        accRead  = 1'b0,
        accWrite = 1'b1
    } accessT;

endpackage

`default_nettype wire

// File: logic/memReqIf.sv
`timescale 1ns/1ps
`default_nettype none

interface memReqIf;
    import memCtrlPkg::*;

    // request side, held steady from grant until done
    logic   req;
    accessT kind;
    addrT   addr;
    lenT    len;
    wordT   wdata;

    // completion side, rdata only meaningful with done
    logic   done;
    wordT   rdata;

    modport arbiter (
        output req,
        output kind,
        output addr,
        output len,
        output wdata,
        input  done,
        input  rdata
    );

    modport engine (
        input  req,
        input  kind,
        input  addr,
        input  len,
        input  wdata,
        output done,
        output rdata
    );

endinterface

`default_nettype wire

// File: logic/memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_pause,

    // instruction fetch requester
    input  logic               i_fetchEn,
    input  memCtrlPkg::addrT   i_fetchAddr,

    // data requester
    input  logic               i_dataEn,
    input  memCtrlPkg::accessT i_dataKind,
    input  memCtrlPkg::addrT   i_dataAddr,
    input  memCtrlPkg::lenT    i_dataLen,
    input  memCtrlPkg::wordT   i_dataWdata,

    // results
    output logic               o_fetchDone,
    output memCtrlPkg::wordT   o_fetchInst,
    output logic               o_dataDone,
    output memCtrlPkg::wordT   o_dataRdata,

    memReqIf.arbiter           bus
);
    import memCtrlPkg::*;

    logic grantQ;
    logic grantDataQ;
    logic anyEn;
    logic useData;
    logic useFetch;

    assign anyEn = i_dataEn || i_fetchEn;

    // held grant decides, otherwise data beats fetch
    always_comb begin
        if (grantQ) begin
            useData  = grantDataQ;
            useFetch = !grantDataQ;
        end else begin
            useData  = i_dataEn;
            useFetch = !i_dataEn && i_fetchEn;
        end
    end

    assign bus.req = useData || useFetch;

    // request fields come straight from the winner,
    // the requester keeps them stable until its done
    always_comb begin
        bus.kind  = accRead;
        bus.addr  = i_fetchAddr;
        bus.len   = FetchLen;
        bus.wdata = '0;
        if (useData) begin
            bus.kind  = i_dataKind;
            bus.addr  = i_dataAddr;
            bus.len   = i_dataLen;
            bus.wdata = i_dataWdata;
        end
    end

    // grant taken at the end of the start cycle, dropped by done
    always_ff @(posedge clk) begin
        if (rst) begin
            grantQ     <= 1'b0;
            grantDataQ <= 1'b0;
        end else if (!i_pause) begin
            if (bus.done) begin
                grantQ <= 1'b0;
            end else if (!grantQ && anyEn) begin
                grantQ     <= 1'b1;
                grantDataQ <= i_dataEn;
            end
        end
    end

    // steer completion back, the loser sees zeros
    assign o_fetchDone = bus.done && useFetch;
    assign o_dataDone  = bus.done && useData;

    always_comb begin
        o_fetchInst = '0;
        o_dataRdata = '0;
        if (useFetch) begin
            o_fetchInst = bus.rdata;
        end
        if (useData) begin
            o_dataRdata = bus.rdata;
        end
    end

endmodule

`default_nettype wire

// File: logic/byteEngine.sv
`timescale 1ns/1ps
`default_nettype none

module byteEngine (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_pause,

    memReqIf.engine             bus,

    // byte RAM, one cycle read latency
    input  memCtrlPkg::memByteT i_memRdata,
    output memCtrlPkg::addrT    o_memAddr,
    output logic                o_memWe,
    output memCtrlPkg::memByteT o_memWdata
);
    import memCtrlPkg::*;

    logic       busyQ;
    lenT        cntQ;
    wordT       asmQ;
    addrT       addrHoldQ;

    logic       start;
    logic       run;
    logic       isRead;
    logic       lastRead;
    logic       lastWrite;
    logic       done;
    lenT        lastIdx;
    addrT       liveAddr;
    wordT       fullWord;
    logic [1:0] byteSel;
    logic [4:0] dropBits;

    // cycle 0 of a transfer is the first unpaused cycle with req seen
    assign start  = bus.req && !busyQ;
    assign run    = busyQ || start;
    assign isRead = (bus.kind == accRead);

    // counter is zero while idle, so the start cycle uses byte 0
    assign liveAddr = bus.addr + addrT'(cntQ);
    assign byteSel  = cntQ[1:0];

    // reads finish one cycle after the last address,
    // writes finish with the last byte written
    assign lastIdx   = bus.len - lenT'(1);
    assign lastRead  = isRead && (cntQ == bus.len);
    assign lastWrite = !isRead && (cntQ == lastIdx);
    assign done      = run && !i_pause && (lastRead || lastWrite);

    assign bus.done = done;

    // newest byte enters at the top, older ones move down
    assign fullWord = {i_memRdata, asmQ[WordWidth-1:ByteWidth]};

    // a short load sits in the upper bytes, move it down and zero-fill
    assign dropBits  = 5'(ByteWidth * (FetchLen - bus.len));
    assign bus.rdata = fullWord >> dropBits;

    // RAM side
    assign o_memWe    = run && !isRead && !i_pause;
    assign o_memWdata = bus.wdata[ByteWidth*byteSel +: ByteWidth];

    // keep the last address during a pause so the RAM output stays put
    assign o_memAddr = i_pause ? addrHoldQ : liveAddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            busyQ <= 1'b0;
            cntQ  <= '0;
        end else if (!i_pause) begin
            if (done) begin
                busyQ <= 1'b0;
                cntQ  <= '0;
            end else if (run) begin
                busyQ <= 1'b1;
                cntQ  <= cntQ + lenT'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addrHoldQ <= '0;
        end else if (!i_pause) begin
            addrHoldQ <= liveAddr;
        end
    end

    // shift on every read cycle; the stale byte taken in cycle 0
    // drops out below the bytes that are kept
    always_ff @(posedge clk) begin
        if (run && isRead && !i_pause) begin
            asmQ <= fullWord;
        end
    end

endmodule

`default_nettype wire

// File: logic/memCtrlTop.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrlTop (
    input  logic                clk,
    input  logic                rst,

    // global stall levels
    input  logic                i_rdy,
    input  logic                i_ioBufferFull,

    // instruction fetch
    input  logic                i_fetchEn,
    input  memCtrlPkg::addrT    i_fetchAddr,
    output logic                o_fetchDone,
    output memCtrlPkg::wordT    o_fetchInst,

    // data port
    input  logic                i_dataEn,
    input  memCtrlPkg::accessT  i_dataKind,
    input  memCtrlPkg::addrT    i_dataAddr,
    input  memCtrlPkg::lenT     i_dataLen,
    input  memCtrlPkg::wordT    i_dataWdata,
    output logic                o_dataDone,
    output memCtrlPkg::wordT    o_dataRdata,

    // byte RAM
    input  memCtrlPkg::memByteT i_memRdata,
    output memCtrlPkg::addrT    o_memAddr,
    output logic                o_memWe,
    output memCtrlPkg::memByteT o_memWdata
);

    logic pause;

    // either level freezes the whole controller
    assign pause = !i_rdy || i_ioBufferFull;

    memReqIf reqBus ();

    memArbiter arbiter (
        .clk         (clk),
        .rst         (rst),
        .i_pause     (pause),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .i_dataEn    (i_dataEn),
        .i_dataKind  (i_dataKind),
        .i_dataAddr  (i_dataAddr),
        .i_dataLen   (i_dataLen),
        .i_dataWdata (i_dataWdata),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata),
        .bus         (reqBus.arbiter)
    );

    byteEngine engine (
        .clk        (clk),
        .rst        (rst),
        .i_pause    (pause),
        .bus        (reqBus.engine),
        .i_memRdata (i_memRdata),
        .o_memAddr  (o_memAddr),
        .o_memWe    (o_memWe),
        .o_memWdata (o_memWdata)
    );

endmodule

`default_nettype wire

// File: tests/byteRamModel.sv
`timescale 1ns/1ps
`default_nettype none

module byteRamModel (
    input  logic                clk,
    input  memCtrlPkg::addrT    i_addr,
    input  logic                i_we,
    input  memCtrlPkg::memByteT i_wdata,
    output memCtrlPkg::memByteT o_rdata
);
    import memCtrlPkg::*;

    localparam int Depth    = 256;
    localparam int IdxWidth = 8;

    // contents are loaded by the testbench before the first clock edge
    memByteT mem [0:Depth-1];

    logic [IdxWidth-1:0] idx;

    // only the low address bits select a byte, upper bits wrap
    assign idx = i_addr[IdxWidth-1:0];

    // synchronous port, read data shows up one cycle after the address
    // a write in the same cycle returns the old byte
    always @(posedge clk) begin
        if (i_we) begin
            mem[idx] <= i_wdata;
        end
        o_rdata <= mem[idx];
    end

endmodule

`default_nettype wire

// File: tests/memCtrlTb.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrlTb;
    import memCtrlPkg::*;

    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 5;
    localparam int RamDepth    = 256;

    localparam int NumFetch   = 20;
    localparam int NumStore   = 30;
    localparam int NumLoad    = 30;
    localparam int NumContend = 20;
    localparam int NumPaused  = 60;

    // each store is read back, contention and paused cases may move two words
    localparam int NumTxn = NumFetch + 2 * NumStore + NumLoad + 2 * NumContend + 2 * NumPaused;
    localparam int WatchdogCycles = NumTxn * 20 + ResetCycles + 10;

    logic    clk;
    logic    rst;
    logic    rdy;
    logic    ioBufferFull;
    logic    fetchEn;
    addrT    fetchAddr;
    logic    fetchDone;
    wordT    fetchInst;
    logic    dataEn;
    accessT  dataKind;
    addrT    dataAddr;
    lenT     dataLen;
    wordT    dataWdata;
    logic    dataDone;
    wordT    dataRdata;
    memByteT memRdata;
    addrT    memAddr;
    logic    memWe;
    memByteT memWdata;

    // reference copy of the RAM and the writes still to come
    memByteT refMem [0:RamDepth-1];
    addrT    expWrAddr [$];
    memByteT expWrData [$];
    string   curTest;

    memCtrlTop i_dut (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (rdy),
        .i_ioBufferFull (ioBufferFull),
        .i_fetchEn      (fetchEn),
        .i_fetchAddr    (fetchAddr),
        .o_fetchDone    (fetchDone),
        .o_fetchInst    (fetchInst),
        .i_dataEn       (dataEn),
        .i_dataKind     (dataKind),
        .i_dataAddr     (dataAddr),
        .i_dataLen      (dataLen),
        .i_dataWdata    (dataWdata),
        .o_dataDone     (dataDone),
        .o_dataRdata    (dataRdata),
        .i_memRdata     (memRdata),
        .o_memAddr      (memAddr),
        .o_memWe        (memWe),
        .o_memWdata     (memWdata)
    );

    byteRamModel ram (
        .clk     (clk),
        .i_addr  (memAddr),
        .i_we    (memWe),
        .i_wdata (memWdata),
        .o_rdata (memRdata)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Timeout: the run did not finish within %0d cycles", WatchdogCycles);
        $display("Errors found");
        $fatal(1);
    end

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // little-endian word from the reference copy, zero above len bytes
    function automatic wordT readModel(input addrT addr, input int len);
        wordT w;
        w = '0;
        for (int k = 0; k < len; k++) begin
            w[8*k +: 8] = refMem[8'(addr + addrT'(k))];
        end
        return w;
    endfunction

    task automatic expectStore(input addrT addr, input lenT len, input wordT wdata);
        addrT a;
        for (int k = 0; k < int'(len); k++) begin
            a = addr + addrT'(k);
            expWrAddr.push_back(a);
            expWrData.push_back(wdata[8*k +: 8]);
            refMem[a[7:0]] = wdata[8*k +: 8];
        end
    endtask

    function automatic lenT randLen();
        case ($urandom % 3)
            0:       return 3'd1;
            1:       return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    function automatic accessT randKind();
        return (($urandom % 2) != 0) ? accWrite : accRead;
    endfunction

    task automatic drivePause(input bit enable);
        if (enable) begin
            rdy          = ($urandom % 4) != 0;
            ioBufferFull = ($urandom % 5) == 0;
        end else begin
            rdy          = 1'b1;
            ioBufferFull = 1'b0;
        end
    endtask

    task automatic preloadMemory();
        memByteT b;
        for (int i = 0; i < RamDepth; i++) begin
            b          = memByteT'($urandom);
            refMem[i]  = b;
            ram.mem[i] = b;
        end
    endtask

    task automatic checkIdle(input string name);
        checkEq({name, " fetch done"}, 32'd0, 32'(fetchDone));
        checkEq({name, " data done"}, 32'd0, 32'(dataDone));
        checkEq({name, " write enable"}, 32'd0, 32'(memWe));
    endtask

    // every RAM write must be the next one expected
    always @(negedge clk) begin
        if (!rst && memWe) begin
            checkEq({curTest, " write while paused"}, 32'd0, 32'(!rdy || ioBufferFull));
            checkEq({curTest, " write expected"}, 32'd1, 32'(expWrAddr.size() != 0));
            checkEq({curTest, " write address"}, expWrAddr.pop_front(), memAddr);
            checkEq({curTest, " write data"}, 32'(expWrData.pop_front()), 32'(memWdata));
        end
    end

    // raises one or both requesters in the same cycle and follows them to done
    task automatic runRequests(
        input string  name,
        input bit     doFetch,
        input addrT   fAddr,
        input bit     doData,
        input accessT kind,
        input addrT   dAddr,
        input lenT    len,
        input wordT   wdata,
        input bit     checkLat,
        input bit     withPause
    );
        wordT expFetch;
        wordT expData;
        int   dataLat;
        int   cyc;
        bit   fetchPend;
        bit   dataPend;

        curTest = name;
        expData = '0;
        dataLat = 0;
        if (doData && kind == accWrite) begin
            expectStore(dAddr, len, wdata);
            dataLat = int'(len) - 1;
        end else if (doData) begin
            expData = readModel(dAddr, int'(len));
            dataLat = int'(len);
        end
        // data goes first, so a fetch sees the stored bytes
        expFetch  = readModel(fAddr, int'(FetchLen));
        fetchPend = doFetch;
        dataPend  = doData;

        @(posedge clk);
        #1;
        fetchEn   = doFetch;
        fetchAddr = fAddr;
        dataEn    = doData;
        dataKind  = kind;
        dataAddr  = dAddr;
        dataLen   = len;
        dataWdata = wdata;
        drivePause(withPause);

        cyc = 0;
        while (fetchPend || dataPend) begin
            @(negedge clk);
            if (dataDone) begin
                checkEq({name, " data done without request"}, 32'd1, 32'(dataPend));
                if (kind == accRead) begin
                    checkEq({name, " load data"}, expData, dataRdata);
                end
                if (checkLat) begin
                    checkEq({name, " data latency"}, dataLat, cyc);
                end
                dataPend = 1'b0;
            end
            if (fetchDone) begin
                checkEq({name, " fetch done without request"}, 32'd1, 32'(fetchPend));
                checkEq({name, " fetch ahead of data"}, 32'd0, 32'(dataPend));
                checkEq({name, " fetch word"}, expFetch, fetchInst);
                if (checkLat && !doData) begin
                    checkEq({name, " fetch latency"}, int'(FetchLen), cyc);
                end
                fetchPend = 1'b0;
            end
            cyc++;
            @(posedge clk);
            #1;
            fetchEn = fetchPend;
            dataEn  = dataPend;
            drivePause(withPause);
        end
    endtask

    initial begin
        addrT   a;
        lenT    l;
        accessT k;
        int     pick;

        void'($urandom(32'hbcb2_7d04));
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        dataEn       = 1'b0;
        dataKind     = accRead;
        dataAddr     = '0;
        dataLen      = 3'd1;
        dataWdata    = '0;
        curTest      = "reset";
        preloadMemory();

        repeat (ResetCycles - 1) begin
            @(negedge clk);
            checkIdle("reset");
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            checkIdle("after reset");
        end

        for (int i = 0; i < NumFetch; i++) begin
            runRequests($sformatf("fetch %0d", i), 1'b1, addrT'($urandom),
                        1'b0, accRead, '0, 3'd1, '0, 1'b1, 1'b0);
        end

        // each store is read back right away
        for (int i = 0; i < NumStore; i++) begin
            a = addrT'($urandom);
            l = randLen();
            runRequests($sformatf("store %0d", i), 1'b0, '0,
                        1'b1, accWrite, a, l, wordT'($urandom), 1'b1, 1'b0);
            runRequests($sformatf("readback %0d", i), 1'b0, '0,
                        1'b1, accRead, a, l, '0, 1'b1, 1'b0);
        end

        for (int i = 0; i < NumLoad; i++) begin
            runRequests($sformatf("load %0d", i), 1'b0, '0,
                        1'b1, accRead, addrT'($urandom), randLen(), '0, 1'b1, 1'b0);
        end

        for (int i = 0; i < NumContend; i++) begin
            runRequests($sformatf("contend %0d", i), 1'b1, addrT'($urandom),
                        1'b1, randKind(), addrT'($urandom), randLen(),
                        wordT'($urandom), 1'b0, 1'b0);
        end

        // mixed traffic with random stalls, no cycle counts
        for (int i = 0; i < NumPaused; i++) begin
            pick = $urandom % 3;
            k    = randKind();
            runRequests($sformatf("paused %0d", i), pick != 1, addrT'($urandom),
                        pick != 0, k, addrT'($urandom), randLen(),
                        wordT'($urandom), 1'b0, 1'b1);
        end
        drivePause(1'b0);
        repeat (2) @(posedge clk);

        if (expWrAddr.size() != 0) begin
            $display("%0d expected RAM writes never appeared", expWrAddr.size());
            $display("Errors found");
            $fatal(1);
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: compile.f
logic/memCtrlPkg.sv
logic/memReqIf.sv
logic/memArbiter.sv
logic/byteEngine.sv
logic/memCtrlTop.sv
tests/byteRamModel.sv
tests/memCtrlTb.sv

// File: Bender.yml
package:
  name: mem_ctrl

sources:
  - logic/memCtrlPkg.sv
  - logic/memReqIf.sv
  - logic/memArbiter.sv
  - logic/byteEngine.sv
  - logic/memCtrlTop.sv
  - target: test
    files:
      - tests/byteRamModel.sv
      - tests/memCtrlTb.sv
